// ==== design/i2c_pkg.sv ====
`default_nettype none

package i2c_pkg;

    localparam int unsigned SYS_CLK_HZ = 50_000_000;
    localparam int unsigned SCL_HZ     = 500_000;
    localparam int unsigned CLK_DIV    = SYS_CLK_HZ / (SCL_HZ * 4); // Clocks per quarter SCL

    // First byte of a 10-bit address header
    localparam logic [4:0] ADDR10_PREFIX = 5'b11110;

    // APB register map
    localparam logic [4:0] REG_ADDR   = 5'h00;
    localparam logic [4:0] REG_TXDATA = 5'h04;
    localparam logic [4:0] REG_CTRL   = 5'h08; // Bit 0 start, bit 1 rw
    localparam logic [4:0] REG_STATUS = 5'h0C; // Bit 0 busy, bit 1 done, bit 2 nack
    localparam logic [4:0] REG_RXDATA = 5'h10;

    typedef enum logic [1:0] {
        BIT_START,
        BIT_STOP,
        BIT_WRITE,
        BIT_READ
    } bit_cmd_t;

    typedef enum logic [3:0] {
        IDLE,
        START,
        ADDR_HI,
        ADDR_LO,
        RESTART,
        ADDR_HI_RD,
        DATA_WR,
        DATA_RD,
        ACK_OUT,
        STOP
    } txn_state_t;

endpackage

`default_nettype wire

// ==== design/i2c_bit_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_bit_ctrl import i2c_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire bit_cmd_t cmd,
    input  wire logic     cmd_valid,
    input  wire logic     bit_tx,
    output logic          cmd_done,
    output logic          bit_rx,
    output logic          scl,
    output logic          sda_oe,    // 1 pulls SDA low
    input  wire logic     sda_in
);

    logic                       active;
    logic [$clog2(CLK_DIV)-1:0] div_cnt;
    logic [1:0]                 phase;
    logic                       quarter_tick;

    // Line levels for one quarter of a command, returned as {scl, sda_oe}
    function automatic logic [1:0] phase_levels(
        input bit_cmd_t   c,
        input logic [1:0] ph,
        input logic       tx,
        input logic       scl_now
    );
        logic [1:0] lv;
        logic       scl_high;
        scl_high = (ph == 2'd1) || (ph == 2'd2);
        case (c)
            BIT_START: begin
                // Release SDA first so a repeated START works from SCL low
                case (ph)
                    2'd0:    lv = {scl_now, 1'b0};
                    2'd1:    lv = 2'b10;
                    2'd2:    lv = 2'b11;  // SDA falls with SCL high
                    default: lv = 2'b01;
                endcase
            end
            BIT_STOP: begin
                case (ph)
                    2'd0:    lv = 2'b01;
                    2'd1:    lv = 2'b11;
                    default: lv = 2'b10;  // SDA rises with SCL high
                endcase
            end
            BIT_WRITE: lv = {scl_high, ~tx};
            default:   lv = {scl_high, 1'b0}; // Read leaves SDA to the slave
        endcase
        return lv;
    endfunction

    assign quarter_tick = active && (div_cnt == $bits(div_cnt)'(CLK_DIV - 1));
    assign cmd_done     = quarter_tick && (phase == 2'd3);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active  <= 1'b0;
            div_cnt <= '0;
            phase   <= '0;
            scl     <= 1'b1;
            sda_oe  <= 1'b0;
        end else if (!active) begin
            if (cmd_valid) begin   // New command restarts the divider
                active          <= 1'b1;
                div_cnt         <= '0;
                phase           <= '0;
                {scl, sda_oe}   <= phase_levels(cmd, 2'd0, bit_tx, scl);
            end
        end else if (quarter_tick) begin
            div_cnt <= '0;
            phase   <= phase + 2'd1;
            if (phase == 2'd3)
                active <= 1'b0;    // Lines hold their last levels while idle
            else
                {scl, sda_oe} <= phase_levels(cmd, phase + 2'd1, bit_tx, scl);
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // Middle of the SCL high phase
    always_ff @(posedge clk) begin
        if (quarter_tick && (phase == 2'd1))
            bit_rx <= sda_in;
    end

    a_cmd_held: assert property (
        @(posedge clk) disable iff (rst)
        cmd_valid && !cmd_done |=> cmd_valid && $stable(cmd)
    ) else $error("cmd_valid or cmd changed before cmd_done");

endmodule

`default_nettype wire

// ==== design/i2c_byte_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_byte_ctrl import i2c_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       start_req,
    input  wire logic       rw,          // 1 means read
    input  wire logic [9:0] slave_addr,
    input  wire logic [7:0] tx_data,
    output logic            busy,
    output logic            done,
    output logic            nack,
    output logic [7:0]      rx_data,
    output bit_cmd_t        cmd,
    output logic            cmd_valid,
    output logic            bit_tx,
    input  wire logic       cmd_done,
    input  wire logic       bit_rx
);

    txn_state_t state;
    logic [7:0] shreg;
    logic [3:0] bit_cnt;
    logic       ack_slot;

    assign ack_slot  = (bit_cnt == 4'd8);  // Ninth bit of a sent byte
    assign cmd_valid = (state != IDLE);

    // Command follows the state, so it stays put until cmd_done
    always_comb begin
        cmd    = BIT_WRITE;
        bit_tx = shreg[7];
        case (state)
            START, RESTART: cmd = BIT_START;
            STOP:           cmd = BIT_STOP;
            DATA_RD:        cmd = BIT_READ;
            ACK_OUT:        bit_tx = 1'b1;     // NACK the only data byte
            ADDR_HI, ADDR_LO, ADDR_HI_RD, DATA_WR: begin
                if (ack_slot)
                    cmd = BIT_READ;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= IDLE;
            shreg   <= '0;
            bit_cnt <= '0;
            busy    <= 1'b0;
            done    <= 1'b0;
            nack    <= 1'b0;
            rx_data <= '0;
        end else begin
            done <= 1'b0;
            if (state == IDLE) begin
                if (start_req) begin
                    state   <= START;
                    busy    <= 1'b1;
                    nack    <= 1'b0;
                    bit_cnt <= '0;
                    shreg   <= {ADDR10_PREFIX, slave_addr[9:8], 1'b0}; // Header, R/W = 0
                end
            end else if (cmd_done) begin
                case (state)
                    START: state <= ADDR_HI;
                    ADDR_HI, ADDR_LO, ADDR_HI_RD, DATA_WR: begin
                        if (!ack_slot) begin
                            shreg   <= {shreg[6:0], 1'b0};
                            bit_cnt <= bit_cnt + 4'd1;
                        end else if (bit_rx) begin
                            nack  <= 1'b1;         // Slave refused, finish with STOP
                            state <= STOP;
                        end else begin
                            bit_cnt <= '0;
                            case (state)
                                ADDR_HI: begin
                                    state <= ADDR_LO;
                                    shreg <= slave_addr[7:0];
                                end
                                ADDR_LO: begin
                                    state <= rw ? RESTART : DATA_WR;
                                    shreg <= tx_data;
                                end
                                ADDR_HI_RD: state <= DATA_RD;
                                default:    state <= STOP;
                            endcase
                        end
                    end
                    RESTART: begin
                        state <= ADDR_HI_RD;
                        shreg <= {ADDR10_PREFIX, slave_addr[9:8], 1'b1};
                    end
                    DATA_RD: begin
                        shreg   <= {shreg[6:0], bit_rx};
                        bit_cnt <= bit_cnt + 4'd1;
                        if (bit_cnt == 4'd7) begin
                            rx_data <= {shreg[6:0], bit_rx};
                            state   <= ACK_OUT;
                        end
                    end
                    ACK_OUT: state <= STOP;
                    default: begin          // STOP finished
                        state <= IDLE;
                        busy  <= 1'b0;
                        done  <= 1'b1;
                    end
                endcase
            end
        end
    end

    // The register file must hold start_req off for the whole transfer
    a_no_start_busy: assert property (
        @(posedge clk) disable iff (rst)
        start_req |-> !busy
    ) else $error("start_req while a transfer is running");

endmodule

`default_nettype wire

// ==== design/i2c_apb_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_apb_regs import i2c_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        psel,
    input  wire logic        penable,
    input  wire logic        pwrite,
    input  wire logic [4:0]  paddr,
    input  wire logic [31:0] pwdata,
    output logic [31:0]      prdata,
    output logic             pready,
    output logic             pslverr,
    output logic             start_req,
    output logic             rw,
    output logic [9:0]       slave_addr,
    output logic [7:0]       tx_data,
    input  wire logic        busy,
    input  wire logic        done,
    input  wire logic        nack,
    input  wire logic [7:0]  rx_data
);

    logic access;
    logic locked;
    logic mapped;
    logic read_only;
    logic done_flag;
    logic nack_flag;

    assign access    = psel && penable;
    assign locked    = busy || start_req;  // Covers the cycle before busy rises
    assign mapped    = paddr inside {REG_ADDR, REG_TXDATA, REG_CTRL, REG_STATUS, REG_RXDATA};
    assign read_only = (paddr == REG_STATUS) || (paddr == REG_RXDATA);
    assign pready    = 1'b1;

    assign pslverr = access && (!mapped || (pwrite && read_only) ||
                     (pwrite && (paddr == REG_CTRL) && pwdata[0] && locked));

    always_comb begin
        prdata = '0;
        case (paddr)
            REG_ADDR:   prdata[9:0] = slave_addr;
            REG_TXDATA: prdata[7:0] = tx_data;
            REG_CTRL:   prdata[1]   = rw;
            REG_STATUS: prdata[2:0] = {nack_flag, done_flag, busy};
            REG_RXDATA: prdata[7:0] = rx_data;
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start_req  <= 1'b0;
            rw         <= 1'b0;
            slave_addr <= '0;
            tx_data    <= '0;
            done_flag  <= 1'b0;
            nack_flag  <= 1'b0;
        end else begin
            start_req <= 1'b0;
            if (done) begin        // Sticky until the next start
                done_flag <= 1'b1;
                nack_flag <= nack;
            end
            if (access && pwrite && !locked) begin
                case (paddr)
                    REG_ADDR:   slave_addr <= pwdata[9:0];
                    REG_TXDATA: tx_data    <= pwdata[7:0];
                    REG_CTRL: begin
                        rw <= pwdata[1];
                        if (pwdata[0]) begin
                            start_req <= 1'b1;
                            done_flag <= 1'b0;
                            nack_flag <= 1'b0;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    a_apb_enable: assert property (
        @(posedge clk) disable iff (rst)
        penable |-> psel
    ) else $error("penable high without psel");

endmodule

`default_nettype wire

// ==== design/i2c_master_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_master_top import i2c_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        psel,
    input  wire logic        penable,
    input  wire logic        pwrite,
    input  wire logic [4:0]  paddr,
    input  wire logic [31:0] pwdata,
    output logic [31:0]      prdata,
    output logic             pready,
    output logic             pslverr,
    output logic             scl,
    output logic             sda_oe,
    input  wire logic        sda_in
);

    // Register file to byte controller
    logic       start_req;
    logic       rw;
    logic [9:0] slave_addr;
    logic [7:0] tx_data;
    logic       busy;
    logic       done;
    logic       nack;
    logic [7:0] rx_data;

    // Byte controller to bit controller
    bit_cmd_t   cmd;
    logic       cmd_valid;
    logic       bit_tx;
    logic       cmd_done;
    logic       bit_rx;

    i2c_apb_regs i2c_apb_regs_inst (
        .clk        (clk),
        .rst        (rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .start_req  (start_req),
        .rw         (rw),
        .slave_addr (slave_addr),
        .tx_data    (tx_data),
        .busy       (busy),
        .done       (done),
        .nack       (nack),
        .rx_data    (rx_data)
    );

    i2c_byte_ctrl i2c_byte_ctrl_inst (
        .clk        (clk),
        .rst        (rst),
        .start_req  (start_req),
        .rw         (rw),
        .slave_addr (slave_addr),
        .tx_data    (tx_data),
        .busy       (busy),
        .done       (done),
        .nack       (nack),
        .rx_data    (rx_data),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .bit_tx     (bit_tx),
        .cmd_done   (cmd_done),
        .bit_rx     (bit_rx)
    );

    i2c_bit_ctrl i2c_bit_ctrl_inst (
        .clk        (clk),
        .rst        (rst),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .bit_tx     (bit_tx),
        .cmd_done   (cmd_done),
        .bit_rx     (bit_rx),
        .scl        (scl),
        .sda_oe     (sda_oe),
        .sda_in     (sda_in)
    );

endmodule

`default_nettype wire

// ==== verification/i2c_slave_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_slave_model #(
    parameter logic [9:0] OWN_ADDR = 10'h2B6
) (
    input  wire logic       scl,
    input  wire logic       sda,
    input  wire logic [7:0] rd_byte,
    output logic            sda_drive,   // 1 pulls SDA low
    output logic [7:0]      stored
);

    logic       active;
    logic       sending;
    logic       ack_bit;     // Inside our own ACK slot
    logic       addressed;   // Both address bytes matched
    logic       to_send;
    logic       ok;
    logic [3:0] cnt;
    logic [7:0] sh;
    int         byte_n;

    initial begin
        sda_drive = 1'b0;
        stored    = '0;
        active    = 1'b0;
        sending   = 1'b0;
        ack_bit   = 1'b0;
        addressed = 1'b0;
        to_send   = 1'b0;
        cnt       = '0;
        sh        = '0;
        byte_n    = 0;
    end

    always @(negedge sda) begin
        if (scl === 1'b1) begin    // START or repeated START
            active  = 1'b1;
            sending = 1'b0;
            ack_bit = 1'b0;
            cnt     = '0;
            byte_n  = 0;
        end
    end

    always @(posedge sda) begin
        if (scl === 1'b1) begin    // STOP
            active    = 1'b0;
            sending   = 1'b0;
            addressed = 1'b0;
        end
    end

    always @(posedge scl) begin
        if (sending)
            cnt = cnt + 4'd1;
        else if (active && cnt < 8) begin
            sh  = {sh[6:0], sda};
            cnt = cnt + 4'd1;
        end
    end

    always @(negedge scl) begin
        if (sending) begin
            sda_drive = (cnt < 8) ? ~rd_byte[7 - cnt] : 1'b0; // Release for master ACK
        end else if (active && ack_bit) begin
            sda_drive = 1'b0;      // End of ACK slot
            ack_bit   = 1'b0;
            cnt       = '0;
            byte_n    = byte_n + 1;
            if (to_send) begin
                sending   = 1'b1;
                sda_drive = ~rd_byte[7];
            end
        end else if (active && cnt == 8) begin
            to_send = 1'b0;
            case (byte_n)
                0: begin
                    ok = (sh[7:1] == {5'b11110, OWN_ADDR[9:8]}) && (!sh[0] || addressed);
                    to_send = ok && sh[0];
                end
                1: begin
                    ok        = (sh == OWN_ADDR[7:0]);
                    addressed = ok;
                end
                default: begin
                    stored = sh;
                    ok     = 1'b1;
                end
            endcase
            ack_bit   = ok;
            sda_drive = ok;
            if (!ok)
                active = 1'b0;     // Ignore the rest until the next START
        end
    end

endmodule

`default_nettype wire

// ==== verification/i2c_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_checker import i2c_pkg::*; #(
    parameter logic [9:0] OWN_ADDR = 10'h2B6
) (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        psel,
    input  wire logic        penable,
    input  wire logic        pwrite,
    input  wire logic [4:0]  paddr,
    input  wire logic [31:0] pwdata,
    input  wire logic [31:0] prdata,
    input  wire logic        pslverr,
    input  wire logic        scl,
    input  wire logic        sda,
    input  wire logic        sda_oe,
    input  wire logic [7:0]  rd_byte,
    input  wire logic [7:0]  stored,
    output logic [31:0]      bus_errors,
    output logic [31:0]      reg_errors
);

    // Register model
    logic [9:0] model_addr;
    logic [7:0] model_data;
    logic       model_rw;
    logic       model_busy;
    logic       started;
    logic       bus_finished;
    logic       exp_err;
    logic       mapped;

    // Bus decoder
    logic       in_txn;
    logic [7:0] sh;
    int         bit_cnt;
    int         restarts;
    logic [7:0] bytes[$];
    logic       acks[$];

    initial begin
        bus_errors   = 0;
        reg_errors   = 0;
        model_addr   = '0;
        model_data   = '0;
        model_rw     = 1'b0;
        model_busy   = 1'b0;
        started      = 1'b0;
        bus_finished = 1'b0;
        in_txn       = 1'b0;
        sh           = '0;
        bit_cnt      = 0;
        restarts     = 0;
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp, input logic on_bus);
        $display("[ERROR] %0t ns %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
        if (on_bus)
            bus_errors++;
        else
            reg_errors++;
    endtask

    task automatic check_status();
        logic nack_exp;
        nack_exp = (model_addr != OWN_ADDR);
        if (!started) begin
            if (prdata !== 32'd0)
                report_mismatch("STATUS", prdata, 32'd0, 1'b0);
        end else if (prdata[1] === 1'b1) begin
            if (!bus_finished) begin
                $display("Check failed at %0t ns: done set before STOP on the bus", $time);
                reg_errors++;
            end
            if (prdata !== {29'd0, nack_exp, 2'b10})
                report_mismatch("STATUS", prdata, {29'd0, nack_exp, 2'b10}, 1'b0);
        end else if (prdata[0] !== 1'b1) begin
            report_mismatch("STATUS.busy", prdata[0], 1, 1'b0);
        end
    endtask

    always @(negedge rst) begin
        if (scl !== 1'b1)
            report_mismatch("scl", scl, 1, 1'b1);
        if (sda_oe !== 1'b0)
            report_mismatch("sda_oe", sda_oe, 0, 1'b1);
    end

    // APB accesses complete in their access phase
    always @(posedge clk) begin
        if (!rst && psel && penable) begin
            mapped  = (paddr == REG_ADDR) || (paddr == REG_TXDATA) || (paddr == REG_CTRL) ||
                      (paddr == REG_STATUS) || (paddr == REG_RXDATA);
            exp_err = !mapped || (pwrite && (paddr == REG_STATUS || paddr == REG_RXDATA)) ||
                      (pwrite && paddr == REG_CTRL && pwdata[0] && model_busy);
            if (pslverr !== exp_err)
                report_mismatch("pslverr", pslverr, exp_err, 1'b0);
            if (!pwrite && paddr == REG_STATUS)
                check_status();
            if (!pwrite && paddr == REG_RXDATA && started && model_rw &&
                model_addr == OWN_ADDR && prdata !== {24'd0, rd_byte})
                report_mismatch("RXDATA", prdata, {24'd0, rd_byte}, 1'b0);
            if (pwrite && !model_busy) begin    // Writes while busy are dropped
                case (paddr)
                    REG_ADDR:   model_addr = pwdata[9:0];
                    REG_TXDATA: model_data = pwdata[7:0];
                    REG_CTRL: begin
                        model_rw = pwdata[1];
                        if (pwdata[0]) begin
                            model_busy   = 1'b1;
                            started      = 1'b1;
                            bus_finished = 1'b0;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // Expected byte sequence from the register model, compared at STOP
    task automatic compare_transfer();
        logic [7:0] exp_b[$];
        logic       exp_a[$];
        logic [7:0] hdr;
        int         exp_restarts;
        hdr          = {ADDR10_PREFIX, model_addr[9:8], 1'b0};
        exp_restarts = 0;
        exp_b.push_back(hdr);
        exp_a.push_back(model_addr[9:8] != OWN_ADDR[9:8]);
        if (model_addr[9:8] == OWN_ADDR[9:8]) begin
            exp_b.push_back(model_addr[7:0]);
            exp_a.push_back(model_addr != OWN_ADDR);
        end
        if (model_addr == OWN_ADDR && !model_rw) begin
            exp_b.push_back(model_data);
            exp_a.push_back(1'b0);
            if (stored !== model_data)
                report_mismatch("slave stored byte", stored, model_data, 1'b1);
        end else if (model_addr == OWN_ADDR) begin
            exp_restarts = 1;
            exp_b.push_back(hdr | 8'h01);
            exp_a.push_back(1'b0);
            exp_b.push_back(rd_byte);
            exp_a.push_back(1'b1);     // Master NACKs the data byte
        end
        if (restarts != exp_restarts)
            report_mismatch("repeated START count", restarts, exp_restarts, 1'b1);
        if (bytes.size() != exp_b.size()) begin
            report_mismatch("bus byte count", bytes.size(), exp_b.size(), 1'b1);
        end else begin
            foreach (exp_b[i]) begin
                if (bytes[i] !== exp_b[i])
                    report_mismatch("bus byte", bytes[i], exp_b[i], 1'b1);
                if (acks[i] !== exp_a[i])
                    report_mismatch("ack bit", acks[i], exp_a[i], 1'b1);
            end
        end
    endtask

    always @(negedge sda) begin
        if (scl === 1'b1) begin
            if (bit_cnt > 1) begin
                $display("Check failed at %0t ns: SDA fell during a data bit", $time);
                bus_errors++;
            end
            if (in_txn)
                restarts++;
            else begin
                in_txn   = 1'b1;
                restarts = 0;
                bytes.delete();
                acks.delete();
            end
            bit_cnt = 0;
        end
    end

    always @(posedge sda) begin
        if (scl === 1'b1 && in_txn) begin
            if (bit_cnt > 1) begin
                $display("Check failed at %0t ns: SDA rose during a data bit", $time);
                bus_errors++;
            end
            compare_transfer();
            in_txn       = 1'b0;
            model_busy   = 1'b0;
            bus_finished = 1'b1;
            bit_cnt      = 0;
        end
    end

    always @(posedge scl) begin
        if (in_txn) begin
            if (bit_cnt < 8)
                sh = {sh[6:0], sda};
            else begin
                bytes.push_back(sh);
                acks.push_back(sda);   // Ninth bit
            end
            bit_cnt = (bit_cnt == 8) ? 0 : bit_cnt + 1;
        end
    end

endmodule

`default_nettype wire

// ==== verification/tb_i2c_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_i2c_master import i2c_pkg::*; ();

    localparam logic [9:0] OWN_ADDR   = 10'h2B6;
    localparam int         NUM_TXN    = 20;
    localparam int         POLL_LIMIT = 400;

    logic             clk;
    logic             rst;
    logic             psel;
    logic             penable;
    logic             pwrite;
    logic [4:0]       paddr;
    logic [31:0]      pwdata;
    wire logic [31:0] prdata;
    wire logic        pready;
    wire logic        pslverr;
    wire logic        scl;
    wire logic        sda_oe;
    wire logic        slave_drive;
    wire logic        sda;
    wire logic [7:0]  stored;
    wire logic [31:0] bus_errors;
    wire logic [31:0] reg_errors;
    logic [7:0]       rd_byte;    // Byte the slave returns on the next read
    logic [31:0]      rdata;
    logic             slverr;
    integer           seed;
    int               timeouts;
    int               n;

    assign sda = !(sda_oe || slave_drive);  // Open drain, either side pulls low

    i2c_master_top i2c_master_top_inst (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .scl     (scl),
        .sda_oe  (sda_oe),
        .sda_in  (sda)
    );

    i2c_slave_model #(.OWN_ADDR(OWN_ADDR)) i2c_slave_model_inst (
        .scl       (scl),
        .sda       (sda),
        .rd_byte   (rd_byte),
        .sda_drive (slave_drive),
        .stored    (stored)
    );

    i2c_checker #(.OWN_ADDR(OWN_ADDR)) checker_inst (
        .clk        (clk),
        .rst        (rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pslverr    (pslverr),
        .scl        (scl),
        .sda        (sda),
        .sda_oe     (sda_oe),
        .rd_byte    (rd_byte),
        .stored     (stored),
        .bus_errors (bus_errors),
        .reg_errors (reg_errors)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // One APB transfer, setup then access phase
    task automatic apb_access(input logic wr, input logic [4:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rd,
                              output logic err);
        int wait_cnt;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        for (wait_cnt = 0; wait_cnt < 16; wait_cnt++) begin
            @(posedge clk);
            if (pready === 1'b1)
                break;
        end
        if (pready !== 1'b1) begin
            $display("Timeout: APB access to offset 0x%0h never completed", addr);
            timeouts++;
        end
        rd  = prdata;
        err = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic run_transfer(input int idx);
        logic [31:0] rnd;
        logic [31:0] other;
        logic [31:0] status;
        logic [9:0]  addr;
        logic        rw;
        int          polls;
        rnd  = $random(seed);
        addr = OWN_ADDR;
        if (rnd[1:0] == 2'b00) begin      // About one in four goes to another slave
            other = $random(seed);
            if (other[9:0] == 10'd0)
                other[0] = 1'b1;
            addr = OWN_ADDR ^ other[9:0];
        end
        rw      = rnd[2];
        rd_byte = rnd[23:16];
        apb_access(1'b1, REG_ADDR, {22'd0, addr}, rdata, slverr);
        apb_access(1'b1, REG_TXDATA, {24'd0, rnd[15:8]}, rdata, slverr);
        apb_access(1'b1, REG_CTRL, {30'd0, rw, 1'b1}, rdata, slverr);
        if (rnd[3])
            apb_access(1'b1, REG_CTRL, {30'd0, ~rw, 1'b1}, rdata, slverr); // Refused
        polls  = 0;
        status = '0;
        while (status[1] !== 1'b1 && polls < POLL_LIMIT && timeouts == 0) begin
            repeat (20) @(negedge clk);
            apb_access(1'b0, REG_STATUS, 32'd0, status, slverr);
            polls++;
        end
        if (status[1] !== 1'b1) begin
            $display("Timeout: transfer %0d never reported done", idx);
            timeouts++;
        end else if (rw) begin
            apb_access(1'b0, REG_RXDATA, 32'd0, rdata, slverr);
        end
    endtask

    initial begin
        seed     = 32'h9d6d_0d62;
        timeouts = 0;
        rst      = 1'b1;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        rd_byte  = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        apb_access(1'b0, REG_STATUS, 32'd0, rdata, slverr);  // Reset value
        apb_access(1'b0, 5'h14, 32'd0, rdata, slverr);       // Unmapped offsets
        apb_access(1'b1, 5'h1C, 32'h5A, rdata, slverr);
        apb_access(1'b1, REG_STATUS, 32'h7, rdata, slverr);  // Read only
        for (n = 0; n < NUM_TXN && timeouts == 0; n++)
            run_transfer(n);
        repeat (10) @(negedge clk);
        $display("Checks done: %0d bus errors, %0d register errors, %0d timeouts",
                 bus_errors, reg_errors, timeouts);
        if (bus_errors == 0 && reg_errors == 0 && timeouts == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
design/i2c_pkg.sv
design/i2c_bit_ctrl.sv
design/i2c_byte_ctrl.sv
design/i2c_apb_regs.sv
design/i2c_master_top.sv
verification/i2c_slave_model.sv
verification/i2c_checker.sv
verification/tb_i2c_master.sv
